// File: bf16_log2_defs.svh
/*
 * BF16 log2 pipeline constants.
 * Field widths, exponent bias, table geometry and special encodings.
 */
`ifndef BF16_LOG2_DEFS_SVH
`define BF16_LOG2_DEFS_SVH

// ========================================
// BF16 word layout
// ========================================
`define BF16_W          16      // Sign + exponent + mantissa
`define EXP_W           8
`define MANT_W          7       // Stored bits, hidden one not included
`define EXP_BIAS        127

// ========================================
// Fraction table
// ========================================
`define FRAC_W          8       // Table output in units of 1/256
`define ROM_ADDR_W      5       // Top mantissa bits, 32 entries

// ========================================
// Special results
// ========================================
`define BF16_POS_INF    16'h7F80
`define BF16_NEG_INF    16'hFF80
`define BF16_QNAN       16'h7FC0        // Quiet NaN, positive sign

`endif

// File: bf16_log2_pkg.sv
/*
 * BF16 log2 shared types.
 * Vector typedefs and the stage-to-stage record.
 */
`default_nettype none

`include "bf16_log2_defs.svh"

package bf16_log2_pkg;

        // Plain vectors
        typedef logic [`BF16_W-1:0]     bf16_t;
        typedef logic [`EXP_W-1:0]      bf16_exp_t;     // Biased
        typedef logic [`MANT_W-1:0]     bf16_mant_t;
        typedef logic signed [`EXP_W:0] log_int_t;      // -127 .. +128
        typedef logic [`FRAC_W-1:0]     log_frac_t;
        typedef logic [`ROM_ADDR_W-1:0] rom_addr_t;

        // Input class flags
        // is_nan is also set for any negative input
        typedef struct packed {
                logic is_zero;  // Zero or subnormal
                logic is_inf;
                logic is_nan;
                logic is_neg;
        } bf16_class_t;

        // ========================================
        // Stage 1 result
        // ========================================
        typedef struct packed {
                log_int_t    int_part;  // Unbiased exponent
                log_frac_t   frac;      // log2 of the significand
                bf16_class_t cls;
        } log_parts_t;

endpackage

`default_nettype wire

// File: bf16_log2_frac_rom.sv
/*
 * Fraction table for BF16 log2.
 * Entry k holds round(256 * log2(1 + k/32)).
 */
`timescale 1ns/1ps
`default_nettype none

module bf16_log2_frac_rom (
        input  bf16_log2_pkg::rom_addr_t rom_addr,
        output bf16_log2_pkg::log_frac_t frac
);

        // Pure lookup, no clock
        always_comb begin
                case (rom_addr)
                        5'd0:  frac = 8'd0;     // Significand 1.0
                        5'd1:  frac = 8'd11;
                        5'd2:  frac = 8'd22;
                        5'd3:  frac = 8'd33;
                        5'd4:  frac = 8'd44;
                        5'd5:  frac = 8'd54;
                        5'd6:  frac = 8'd63;
                        5'd7:  frac = 8'd73;
                        5'd8:  frac = 8'd82;    // 1.25
                        5'd9:  frac = 8'd92;
                        5'd10: frac = 8'd100;
                        5'd11: frac = 8'd109;
                        5'd12: frac = 8'd118;
                        5'd13: frac = 8'd126;
                        5'd14: frac = 8'd134;
                        5'd15: frac = 8'd142;
                        5'd16: frac = 8'd150;   // 1.5
                        5'd17: frac = 8'd157;
                        5'd18: frac = 8'd165;
                        5'd19: frac = 8'd172;
                        5'd20: frac = 8'd179;
                        5'd21: frac = 8'd186;
                        5'd22: frac = 8'd193;
                        5'd23: frac = 8'd200;
                        5'd24: frac = 8'd207;   // 1.75
                        5'd25: frac = 8'd213;
                        5'd26: frac = 8'd220;
                        5'd27: frac = 8'd226;
                        5'd28: frac = 8'd232;
                        5'd29: frac = 8'd238;
                        5'd30: frac = 8'd244;
                        5'd31: frac = 8'd250;   // Largest step below 1.0
                endcase
        end

endmodule

`default_nettype wire

// File: bf16_log2_decode.sv
/*
 * BF16 log2, stage 1.
 * Splits the input, classifies it, forms the integer part and looks up
 * the fraction, then registers everything as one record.
 */
`timescale 1ns/1ps
`default_nettype none

`include "bf16_log2_defs.svh"

module bf16_log2_decode (
        input  logic                      clk,
        input  logic                      rst,
        input  bf16_log2_pkg::bf16_t      x,
        input  logic                      x_valid,
        output bf16_log2_pkg::log_parts_t parts,
        output logic                      parts_valid
);
        import bf16_log2_pkg::*;

        logic        sign;
        bf16_exp_t   exp_b;
        bf16_mant_t  mant;
        logic        exp_max;
        logic        nan_in;
        bf16_class_t cls;
        log_int_t    int_part;
        rom_addr_t   rom_addr;
        log_frac_t   frac;
        log_parts_t  parts_next;

        // ========================================
        // Field split and classification
        // ========================================
        assign sign  = x[`BF16_W-1];
        assign exp_b = x[`BF16_W-2 -: `EXP_W];
        assign mant  = x[`MANT_W-1:0];

        assign exp_max = (exp_b == {`EXP_W{1'b1}});
        assign nan_in  = exp_max && (mant != '0);

        assign cls.is_zero = (exp_b == '0);     // Subnormals count as zero
        assign cls.is_inf  = exp_max && (mant == '0);
        assign cls.is_nan  = nan_in || sign;
        assign cls.is_neg  = sign && !nan_in;

        // Integer part is the unbiased exponent
        assign int_part = log_int_t'({1'b0, exp_b}) - log_int_t'(`EXP_BIAS);

        // Fraction from the top mantissa bits
        assign rom_addr = mant[`MANT_W-1 -: `ROM_ADDR_W];

        bf16_log2_frac_rom u_frac_rom (
                .rom_addr (rom_addr),
                .frac     (frac)
        );

        assign parts_next = '{int_part: int_part, frac: frac, cls: cls};

        // ========================================
        // Stage register
        // ========================================
        always_ff @(posedge clk) begin
                parts <= parts_next;
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        parts_valid <= 1'b0;
                end else begin
                        parts_valid <= x_valid;
                end
        end

endmodule

`default_nettype wire

// File: bf16_log2_normalize.sv
/*
 * BF16 log2, stage 2.
 * Folds negative logs to sign and magnitude, normalizes the fixed point
 * value into BF16 by truncation and applies the special-case results.
 */
`timescale 1ns/1ps
`default_nettype none

`include "bf16_log2_defs.svh"

module bf16_log2_normalize (
        input  logic                       clk,
        input  logic                       rst,
        input  bf16_log2_pkg::log_parts_t  parts,
        input  logic                       parts_valid,
        output bf16_log2_pkg::bf16_t       log2_y,
        output bf16_log2_pkg::bf16_class_t flags,
        output logic                       log_valid
);
        import bf16_log2_pkg::*;

        localparam int MAG_W  = `EXP_W + `FRAC_W;       // 8.8 fixed point
        localparam int LEAD_W = $clog2(MAG_W);

        logic              neg;
        logic              frac_nz;
        log_int_t          neg_int;
        logic [`EXP_W-1:0] abs_int;
        logic [MAG_W-1:0]  mag;
        logic [LEAD_W-1:0] lead;
        logic [MAG_W-1:0]  norm;
        bf16_exp_t         res_exp;
        bf16_mant_t        res_mant;
        bf16_t             res_word;
        bf16_t             y_next;

        // ========================================
        // Sign and magnitude
        // ========================================
        assign neg     = parts.int_part[`EXP_W];
        assign frac_nz = (parts.frac != '0);
        assign neg_int = -parts.int_part;
        assign abs_int = neg ? neg_int[`EXP_W-1:0] : parts.int_part[`EXP_W-1:0];

        // -n + f/256 becomes -((n - 1) + (256 - f)/256)
        assign mag = (neg && frac_nz) ?
                     {abs_int - 8'd1, 8'd0 - parts.frac} :
                     {abs_int, parts.frac};

        // ========================================
        // Leading one and truncation
        // ========================================
        always_comb begin
                lead = '0;
                for (int i = 0; i < MAG_W; i++) begin
                        if (mag[i]) begin
                                lead = LEAD_W'(i);      // Highest set bit wins
                        end
                end
        end

        assign norm     = mag << (LEAD_W'(MAG_W - 1) - lead);
        assign res_mant = norm[MAG_W-2 -: `MANT_W];    // Bits below the leading one
        // Bit position lead is worth 2^(lead - FRAC_W)
        assign res_exp  = 8'(`EXP_BIAS - `FRAC_W) + bf16_exp_t'(lead);

        assign res_word = (mag == '0) ? '0 : {neg, res_exp, res_mant};

        // Special cases override the computed word
        always_comb begin
                if (parts.cls.is_nan) begin
                        y_next = `BF16_QNAN;
                end else if (parts.cls.is_zero) begin
                        y_next = `BF16_NEG_INF;
                end else if (parts.cls.is_inf) begin
                        y_next = `BF16_POS_INF;
                end else begin
                        y_next = res_word;
                end
        end

        // ========================================
        // Output register
        // ========================================
        always_ff @(posedge clk) begin
                log2_y <= y_next;
                flags  <= parts.cls;
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        log_valid <= 1'b0;
                end else begin
                        log_valid <= parts_valid;
                end
        end

endmodule

`default_nettype wire

// File: bf16_log2.sv
/*
 * BF16 base-2 logarithm, two-stage pipeline.
 * One input per cycle, result two cycles later.
 */
`timescale 1ns/1ps
`default_nettype none

module bf16_log2 (
        input  logic                       clk,
        input  logic                       rst,
        input  bf16_log2_pkg::bf16_t       x,
        input  logic                       x_valid,
        output bf16_log2_pkg::bf16_t       log2_y,
        output bf16_log2_pkg::bf16_class_t flags,
        output logic                       log_valid
);
        import bf16_log2_pkg::*;

        log_parts_t parts;      // Between the two stages
        logic       parts_valid;

        // ========================================
        // Stage 1, decode and lookup
        // ========================================
        bf16_log2_decode u_decode (
                .clk         (clk),
                .rst         (rst),
                .x           (x),
                .x_valid     (x_valid),
                .parts       (parts),
                .parts_valid (parts_valid)
        );

        // ========================================
        // Stage 2, combine and normalize
        // ========================================
        bf16_log2_normalize u_normalize (
                .clk         (clk),
                .rst         (rst),
                .parts       (parts),
                .parts_valid (parts_valid),
                .log2_y      (log2_y),
                .flags       (flags),
                .log_valid   (log_valid)
        );

endmodule

`default_nettype wire

// File: bf16_log2_assertions.sv
/*
 * Bound checks for the BF16 log2 pipeline.
 * Two-cycle valid latency and consistency of the class flags.
 */
`timescale 1ns/1ps
`default_nettype none

module bf16_log2_assertions (
        input logic                       clk,
        input logic                       rst,
        input logic                       x_valid,
        input logic                       log_valid,
        input bf16_log2_pkg::bf16_class_t flags
);
        import bf16_log2_pkg::*;

        // ========================================
        // Pipeline timing
        // ========================================
        a_valid_delay : assert property (@(posedge clk) disable iff (rst)
                log_valid == $past(x_valid, 2))
                else $error("log_valid does not follow x_valid by two cycles");

        // ========================================
        // Flag consistency
        // ========================================
        a_neg_is_nan : assert property (@(posedge clk) disable iff (rst)
                (log_valid && flags.is_neg) |-> flags.is_nan)
                else $error("is_neg raised without is_nan");

        a_zero_not_inf : assert property (@(posedge clk) disable iff (rst)
                log_valid |-> !(flags.is_zero && flags.is_inf))
                else $error("is_zero and is_inf raised together");

endmodule

bind bf16_log2 bf16_log2_assertions u_assertions (
        .clk       (clk),
        .rst       (rst),
        .x_valid   (x_valid),
        .log_valid (log_valid),
        .flags     (flags)
);

`default_nettype wire

// File: bf16_log2_tb.sv
/*
 * Testbench for the BF16 log2 pipeline.
 * Directed and random inputs checked against a real-valued model.
 */
`timescale 1ns/1ps
`default_nettype none

module bf16_log2_tb;
        import bf16_log2_pkg::*;

        typedef struct packed {
                bf16_t       x;         // Input that produced it
                bf16_t       y;
                bf16_class_t cls;
                logic [31:0] cyc;       // Cycle the input was driven
        } expect_t;

        logic        clk;
        logic        rst;
        bf16_t       x;
        logic        x_valid;
        bf16_t       log2_y;
        bf16_class_t flags;
        logic        log_valid;

        expect_t     exp_q[$];
        logic [31:0] cycle;
        int          seed;
        int          result_errors;
        int          flag_errors;
        int          protocol_errors;

        bf16_log2 i_bf16_log2 (
                .clk       (clk),
                .rst       (rst),
                .x         (x),
                .x_valid   (x_valid),
                .log2_y    (log2_y),
                .flags     (flags),
                .log_valid (log_valid)
        );

        // ========================================
        // Clock and cycle count
        // ========================================
        initial clk = 1'b0;
        always #2 clk = ~clk;   // 4 ns period

        always @(posedge clk) begin
                cycle <= cycle + 1;
        end

        // ========================================
        // Reference model
        // ========================================
        // 256 * log2(1 + k/32), nearest integer
        function automatic int table_entry(input int k);
                real r;
                r = 256.0 * $ln(1.0 + k / 32.0) / $ln(2.0);
                return $rtoi(r + 0.5);
        endfunction

        function automatic expect_t ref_log2(input bf16_t v);
                expect_t e;
                int      ex;
                int      mn;
                int      val;
                int      m;
                int      p;
                logic    nan_in;
                ex = int'(v[14:7]);
                mn = int'(v[6:0]);
                nan_in = (ex == 255) && (mn != 0);
                e.x = v;
                e.cyc = '0;
                e.cls.is_zero = (ex == 0);
                e.cls.is_inf = (ex == 255) && (mn == 0);
                e.cls.is_nan = nan_in || v[15];
                e.cls.is_neg = v[15] && !nan_in;
                val = (ex - 127) * 256 + table_entry(mn / 4);   // Units of 1/256
                m = (val < 0) ? -val : val;
                p = 0;
                while ((m >> (p + 1)) != 0) begin
                        p++;
                end
                if (m == 0) begin
                        e.y = 16'h0000;
                end else begin
                        // Truncated mantissa below the leading one
                        e.y = {val < 0, bf16_exp_t'(127 + p - 8),
                               bf16_mant_t'(((m - (1 << p)) * 128) >> p)};
                end
                if (e.cls.is_nan) begin
                        e.y = 16'h7FC0;
                end else if (e.cls.is_zero) begin
                        e.y = 16'hFF80;
                end else if (e.cls.is_inf) begin
                        e.y = 16'h7F80;
                end
                return e;
        endfunction

        // ========================================
        // Compare tasks
        // ========================================
        task automatic check_bf16(input bf16_t in_x, input bf16_t got, input bf16_t want);
                if (got !== want) begin
                        $display("FAILED t=%0t: log2(%h) gave %h, expected %h",
                                 $time, in_x, got, want);
                        result_errors++;
                end
        endtask

        task automatic check_flags(input bf16_t in_x, input bf16_class_t got,
                                   input bf16_class_t want);
                if (got !== want) begin
                        $display("FAILED t=%0t: flags for %h are %b, expected %b",
                                 $time, in_x, got, want);
                        flag_errors++;
                end
        endtask

        // Sampled mid-cycle, away from the clock edge
        always @(negedge clk) begin : compare
                expect_t e;
                if (!rst && log_valid === 1'b1) begin
                        if (exp_q.size() == 0) begin
                                $display("Result %h came out at %0t with no input pending",
                                         log2_y, $time);
                                protocol_errors++;
                        end else begin
                                e = exp_q.pop_front();
                                if (cycle != e.cyc + 2) begin
                                        $display("Result for %h came %0d cycles after its input",
                                                 e.x, cycle - e.cyc);
                                        protocol_errors++;
                                end
                                check_bf16(e.x, log2_y, e.y);
                                check_flags(e.x, flags, e.cls);
                        end
                end else if (!rst && log_valid !== 1'b0) begin
                        $display("log_valid is unknown at %0t", $time);
                        protocol_errors++;
                end
        end

        // ========================================
        // Stimulus
        // ========================================
        task automatic drive_item(input bf16_t v, input logic valid);
                expect_t e;
                x = v;
                x_valid = valid;
                if (valid) begin
                        e = ref_log2(v);
                        e.cyc = cycle;
                        exp_q.push_back(e);
                end
                @(posedge clk);
                #1;
        endtask

        // Hand-worked value guards the model too
        task automatic apply_known(input bf16_t v, input bf16_t want);
                expect_t e;
                e = ref_log2(v);
                check_bf16(v, e.y, want);
                drive_item(v, 1'b1);
        endtask

        function automatic bf16_t rand_normal(input logic sgn);
                int        r;
                bf16_exp_t ex;
                r = $random(seed);
                ex = bf16_exp_t'(1 + (r[15:8] % 254));  // 1 .. 254
                return {sgn, ex, r[6:0]};
        endfunction

        initial begin
                int n;
                int r;
                seed = 32'hf7e1f37e;
                rst = 1'b1;
                x = '0;
                x_valid = 1'b0;
                cycle = '0;
                result_errors = 0;
                flag_errors = 0;
                protocol_errors = 0;

                repeat (5) @(posedge clk);
                #1;
                rst = 1'b0;
                @(negedge clk);
                if (log_valid !== 1'b0) begin
                        $display("log_valid is not low after reset");
                        protocol_errors++;
                end
                @(posedge clk);
                #1;

                // Powers of two
                apply_known(16'h3F80, 16'h0000);
                apply_known(16'h4000, 16'h3F80);
                apply_known(16'h3F00, 16'hBF80);
                apply_known(16'h7180, 16'h42C8);        // 2^100

                // Special inputs
                apply_known(16'h0000, 16'hFF80);
                apply_known(16'h0041, 16'hFF80);        // Subnormal
                apply_known(16'h7F80, 16'h7F80);
                apply_known(16'h7FC1, 16'h7FC0);
                apply_known(16'hFFC0, 16'h7FC0);
                apply_known(16'h8000, 16'h7FC0);

                for (n = 0; n < 20; n++) begin
                        drive_item(rand_normal(1'b1), 1'b1);
                end
                for (n = 0; n < 200; n++) begin
                        drive_item(rand_normal(1'b0), 1'b1);
                end

                // Gaps in valid, mixed signs
                for (n = 0; n < 200; n++) begin
                        r = $random(seed);
                        drive_item(rand_normal(r[4] & r[5]), r[0]);
                end
                drive_item(16'h0000, 1'b0);

                for (n = 0; n < 20 && exp_q.size() != 0; n++) begin
                        @(posedge clk);
                end
                if (exp_q.size() != 0) begin
                        $display("Timed out with %0d results still missing", exp_q.size());
                        protocol_errors += exp_q.size();
                end

                $display("Errors: result %0d, flags %0d, protocol %0d",
                         result_errors, flag_errors, protocol_errors);
                if (result_errors + flag_errors + protocol_errors == 0) begin
                        $display("Simulation PASSED");
                end else begin
                        $display("Simulation FAILED");
                end
                $finish;
        end

endmodule

`default_nettype wire

// File: all.f
+incdir+.
bf16_log2_pkg.sv
bf16_log2_frac_rom.sv
bf16_log2_decode.sv
bf16_log2_normalize.sv
bf16_log2.sv
bf16_log2_assertions.sv
bf16_log2_tb.sv

// File: Makefile
# Verilator build and run for the BF16 log2 pipeline

TOP = bf16_log2_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --top-module $(TOP) -f all.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation PASSED" sim.log

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f all.f
	verilator --lint-only --top-module bf16_log2 +incdir+. \
		bf16_log2_pkg.sv bf16_log2_frac_rom.sv bf16_log2_decode.sv \
		bf16_log2_normalize.sv bf16_log2.sv

clean:
	rm -rf obj_dir sim.log
